// File: compile.f
+incdir+include
rtl/radio_pkg.sv
rtl/rx_chan_if.sv
rtl/rx_frontend.sv
rtl/frontend_swap.sv
rtl/vita_timer.sv
rtl/misc_ctrl_regs.sv
rtl/status_readback.sv
rtl/radio_ctrl_core.sv
tests/tb_radio_ctrl_core.sv

// File: Makefile
# Verilator build of the radio control core testbench

TOP = tb_radio_ctrl_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f compile.f \
		--top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

// File: tests/tb_radio_ctrl_core.sv
// Self-checking testbench of radio_ctrl_core, samples outputs on the falling edge
// Expected rx data, LEDs and timer values come from a model of the register rules
`timescale 1ns/100ps
`include "radio_defs_defs.svh"

module tb_radio_ctrl_core
   import radio_pkg::*;
;
   localparam int TEST_CYCLES = 10 + 30 + 300 + 150 + 150 + 120 + 60;   // Reset plus tests

   logic dsp_clk, por_rst, set_stb_i, pps_i, run_rx0_i, run_rx1_i;
   set_addr_t set_addr_i;
   set_data_t set_data_i;
   adc_t adc0_a_i, adc0_b_i, adc1_a_i, adc1_b_i;
   logic [3:0] rb_addr_i;
   sample_t rx0_i_o, rx0_q_o, rx1_i_o, rx1_q_o;
   logic [7:0] leds_o;
   logic [1:0] div_sw_o;
   logic phy_reset_n_o, pps_int_o;
   rb_word_t rb_data_o;

   int errors = 0;
   int checks = 0;
   int tests_failed = 0;
   int tests_run = 0;
   logic [31:0] cyc = '0;
   logic chk_en = 1'b0;
   logic [15:0] ofs_m [4];   // Offset mirror: ch0 I, ch0 Q, ch1 I, ch1 Q
   logic swap_m = 1'b0;
   logic [7:0] src_m = `RADIO_LED_SRC_RESET;
   logic [7:0] sw_m = 8'h00;

   radio_ctrl_core dut0 (.*);

   initial begin
      dsp_clk = 1'b0;
      forever #2 dsp_clk = ~dsp_clk;
   end

   always @(posedge dsp_clk) cyc <= cyc + 1;

   initial begin
      #(TEST_CYCLES * 2 * 4);
      $display("Run stopped by the watchdog after %0d cycles", cyc);
      $display("Testbench failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reference model and compare tasks

   // Left justify, subtract the offset, saturate to 16 bits; returns {ovf, value}
   function automatic logic [16:0] fe_ref(input adc_t smp, input logic [15:0] ofs);
      int v;
      v = int'($signed(smp)) * 16 - int'($signed(ofs));
      if (v > 32767)
         return {1'b1, 16'h7FFF};
      if (v < -32768)
         return {1'b1, 16'h8000};
      return {1'b0, v[15:0]};
   endfunction

   function automatic logic [7:0] led_ref(input logic [7:0] src, input logic [7:0] sw,
                                          input logic r0, input logic r1);
      logic [7:0] hw;
      logic [7:0] res;
      hw = {4'b0000, r0, 1'b0, r1, 1'b0};
      for (int b = 0; b < 8; b++)
         res[b] = src[b] ? hw[b] : sw[b];
      return res;
   endfunction

   function automatic adc_t rand_adc();
      logic [31:0] r;
      r = $urandom();
      return r[11:0];
   endfunction

   task automatic check_sample(input string name, input sample_t got, input sample_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s got %h expected %h at cycle %0d", name, got, exp, cyc);
      end
   endtask

   task automatic check_word(input string name, input rb_word_t got, input rb_word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s got %h expected %h at cycle %0d", name, got, exp, cyc);
      end
   endtask

   task automatic check_leds(input string name, input logic [7:0] got,
                             input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR %s got %h expected %h at cycle %0d", name, got, exp, cyc);
      end
   endtask

   // Two stage model pipeline, compared on every falling edge while enabled
   sample_t e_d1 [4], e_d2 [4];
   logic [1:0] r_d1, r_d2;
   int pipe_cnt = 0;

   always @(negedge dsp_clk) begin
      sample_t ch [4];
      sample_t cur [4];
      if (!chk_en) begin
         pipe_cnt = 0;
      end else begin
         ch[0] = sample_t'({fe_ref(adc0_a_i, ofs_m[0]), 8'h00});   // Drops the ovf bit
         ch[1] = sample_t'({fe_ref(adc0_b_i, ofs_m[1]), 8'h00});
         ch[2] = sample_t'({fe_ref(adc1_a_i, ofs_m[2]), 8'h00});
         ch[3] = sample_t'({fe_ref(adc1_b_i, ofs_m[3]), 8'h00});
         cur[0] = swap_m ? ch[2] : ch[0];
         cur[1] = swap_m ? ch[3] : ch[1];
         cur[2] = swap_m ? ch[0] : ch[2];
         cur[3] = swap_m ? ch[1] : ch[3];
         if (pipe_cnt >= 2) begin
            check_sample("rx0_i_o", rx0_i_o, e_d2[0]);
            check_sample("rx0_q_o", rx0_q_o, e_d2[1]);
            check_sample("rx1_i_o", rx1_i_o, e_d2[2]);
            check_sample("rx1_q_o", rx1_q_o, e_d2[3]);
            check_leds("leds_o", leds_o, led_ref(src_m, sw_m, r_d2[0], r_d2[1]));
         end
         e_d2 = e_d1;
         r_d2 = r_d1;
         e_d1 = cur;
         r_d1 = swap_m ? {run_rx0_i, run_rx1_i} : {run_rx1_i, run_rx0_i};
         pipe_cnt++;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Bus and test helpers

   task automatic bus_write(input int a, input set_data_t d);
      @(posedge dsp_clk);
      set_stb_i  <= 1'b1;
      set_addr_i <= set_addr_t'(a);
      set_data_i <= d;
      @(posedge dsp_clk);
      set_stb_i  <= 1'b0;
   endtask

   task automatic read_word(input logic [3:0] a, output rb_word_t v);
      @(posedge dsp_clk);
      rb_addr_i <= a;
      @(posedge dsp_clk);
      @(negedge dsp_clk);
      v = rb_data_o;
   endtask

   task automatic random_traffic(input int n);
      repeat (n) begin
         @(posedge dsp_clk);
         adc0_a_i  <= rand_adc();
         adc0_b_i  <= rand_adc();
         adc1_a_i  <= rand_adc();
         adc1_b_i  <= rand_adc();
         run_rx0_i <= $urandom_range(1, 0) == 1;
         run_rx1_i <= $urandom_range(1, 0) == 1;
      end
      repeat (3) @(posedge dsp_clk);   // Last samples reach the compare
   endtask

   task automatic report_test(input string name, input int err_before);
      tests_run++;
      if (errors != err_before)
         tests_failed++;
      $display("test %0d %s: %s (%0d errors)", tests_run, name,
               (errors == err_before) ? "ok" : "FAILED", errors - err_before);
   endtask

   task automatic set_offsets(input logic [15:0] o0, input logic [15:0] o1,
                              input logic [15:0] o2, input logic [15:0] o3);
      bus_write(`RADIO_SR_RX_FRONT0, {16'h0000, o0});
      bus_write(`RADIO_SR_RX_FRONT0 + 1, {16'h0000, o1});
      bus_write(`RADIO_SR_RX_FRONT1, {16'h0000, o2});
      bus_write(`RADIO_SR_RX_FRONT1 + 1, {16'h0000, o3});
      ofs_m[0] = o0;
      ofs_m[1] = o1;
      ofs_m[2] = o2;
      ofs_m[3] = o3;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      int e0;
      int cnt;
      rb_word_t v;
      logic [31:0] c2;
      logic [31:0] cq3;
      logic [63:0] t0;
      logic [63:0] t1;
      logic [63:0] cap;
      logic [3:0] flags;
      logic [16:0] cor;
      void'($urandom(32'h5f6b_f436));
      por_rst = 1'b1;
      set_stb_i = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      pps_i = 1'b0;
      run_rx0_i = 1'b1;   // Runs high so the hardware LED bits show
      run_rx1_i = 1'b1;
      adc0_a_i = '0;
      adc0_b_i = '0;
      adc1_a_i = '0;
      adc1_b_i = '0;
      rb_addr_i = '0;
      for (int k = 0; k < 4; k++)
         ofs_m[k] = '0;
      repeat (10) @(posedge dsp_clk);
      por_rst <= 1'b0;

      // 1 Reset values
      e0 = errors;
      repeat (3) @(negedge dsp_clk);
      check_leds("leds_o", leds_o, led_ref(`RADIO_LED_SRC_RESET, 8'h00, 1'b1, 1'b1));
      check_leds("div_sw_o", {6'd0, div_sw_o}, 8'h03);
      check_leds("phy_reset_n_o", {7'd0, phy_reset_n_o}, 8'h01);
      read_word(4'd12, v);
      check_word("rb_data_o word 12", v, `RADIO_COMPAT_NUM);
      report_test("reset values", e0);

      // 2 Random samples and offsets, then overflow flags
      e0 = errors;
      set_offsets(16'($urandom()), 16'($urandom()), 16'($urandom()), 16'($urandom()));
      chk_en = 1'b1;
      random_traffic(250);
      chk_en = 1'b0;
      set_offsets(16'h8000, 16'h0000, 16'h0000, 16'h7FFF);
      @(posedge dsp_clk);
      adc0_a_i <= 12'h7FF;
      adc0_b_i <= 12'h800;
      adc1_a_i <= 12'h7FF;
      adc1_b_i <= 12'h800;
      repeat (4) @(posedge dsp_clk);
      cor = fe_ref(12'h7FF, 16'h8000);
      flags[0] = cor[16];
      cor = fe_ref(12'h800, 16'h0000);
      flags[1] = cor[16];
      cor = fe_ref(12'h7FF, 16'h0000);
      flags[2] = cor[16];
      cor = fe_ref(12'h800, 16'h7FFF);
      flags[3] = cor[16];
      read_word(4'd13, v);
      check_word("rb_data_o word 13", v, {28'd0, flags});
      report_test("rx correction and overflow", e0);

      // 3 Channel swap
      e0 = errors;
      bus_write(`RADIO_SR_RX_FRONT_SW, 32'd1);
      swap_m = 1'b1;
      repeat (2) @(posedge dsp_clk);
      chk_en = 1'b1;
      random_traffic(100);
      chk_en = 1'b0;
      bus_write(`RADIO_SR_RX_FRONT_SW, 32'd0);
      swap_m = 1'b0;
      repeat (2) @(posedge dsp_clk);
      report_test("channel swap", e0);

      // 4 LED mux, diversity and PHY reset
      e0 = errors;
      bus_write(`RADIO_SR_MISC + `RADIO_MISC_LED_SRC_OFS, 32'h0000_000A);
      bus_write(`RADIO_SR_MISC + `RADIO_MISC_LED_SW_OFS, 32'h0000_00F5);
      src_m = 8'h0A;
      sw_m = 8'hF5;
      chk_en = 1'b1;
      random_traffic(40);
      chk_en = 1'b0;
      bus_write(`RADIO_SR_MISC + `RADIO_MISC_LED_SRC_OFS, 32'h0000_0002);
      bus_write(`RADIO_SR_MISC + `RADIO_MISC_LED_SW_OFS, 32'h0000_00FF);
      src_m = 8'h02;
      sw_m = 8'hFF;
      chk_en = 1'b1;
      random_traffic(40);
      chk_en = 1'b0;
      bus_write(`RADIO_SR_DIVSW, 32'd0);
      @(negedge dsp_clk);
      check_leds("div_sw_o", {6'd0, div_sw_o}, 8'h02);
      bus_write(`RADIO_SR_DIVSW + 1, 32'd0);
      @(negedge dsp_clk);
      check_leds("div_sw_o", {6'd0, div_sw_o}, 8'h00);
      bus_write(`RADIO_SR_MISC + `RADIO_MISC_PHY_OFS, 32'd1);
      @(negedge dsp_clk);
      check_leds("phy_reset_n_o", {7'd0, phy_reset_n_o}, 8'h00);
      report_test("leds and control bits", e0);

      // 5 Timer loads and PPS capture
      e0 = errors;
      t0 = 64'h0000_1234_0000_0100;
      t1 = 64'h0000_5678_0000_0200;
      @(posedge dsp_clk);
      rb_addr_i <= 4'd11;
      bus_write(`RADIO_SR_TIME64 + `RADIO_TIME_HI_OFS, t0[63:32]);
      bus_write(`RADIO_SR_TIME64 + `RADIO_TIME_LO_OFS, t0[31:0]);
      bus_write(`RADIO_SR_TIME64 + `RADIO_TIME_CTRL_OFS, 32'd0);
      @(negedge dsp_clk);
      @(negedge dsp_clk);
      c2 = cyc;   // Counter holds t0 from here
      repeat (20) @(posedge dsp_clk);
      @(negedge dsp_clk);
      check_word("rb_data_o word 11", rb_data_o, t0[31:0] + (cyc - 1 - c2));
      read_word(4'd10, v);
      check_word("rb_data_o word 10", v, t0[63:32]);
      bus_write(`RADIO_SR_TIME64 + `RADIO_TIME_HI_OFS, t1[63:32]);
      bus_write(`RADIO_SR_TIME64 + `RADIO_TIME_LO_OFS, t1[31:0]);
      bus_write(`RADIO_SR_TIME64 + `RADIO_TIME_CTRL_OFS, 32'd1);
      repeat (5) @(posedge dsp_clk);
      pps_i <= 1'b1;
      cnt = 0;
      while (cnt < 10) begin
         @(posedge dsp_clk);
         cnt++;
         @(negedge dsp_clk);
         if (pps_int_o)
            break;
      end
      cq3 = cyc;
      cap = t0 + 64'(cq3 - 1 - c2);
      checks++;
      if (!pps_int_o || cnt != 3) begin
         errors++;
         $display("PPS interrupt came %0d cycles after pps_i rose, expected 3", cnt);
      end
      pps_i <= 1'b0;
      read_word(4'd15, v);
      check_word("rb_data_o word 15", v, cap[31:0]);
      read_word(4'd14, v);
      check_word("rb_data_o word 14", v, cap[63:32]);
      read_word(4'd11, v);
      check_word("rb_data_o word 11", v, t1[31:0] + (cyc - 1 - cq3));
      read_word(4'd10, v);
      check_word("rb_data_o word 10", v, t1[63:32]);
      report_test("timer and pps", e0);

      // 6 ADC readback and unused words
      e0 = errors;
      @(posedge dsp_clk);
      adc0_a_i <= 12'hABC;
      adc0_b_i <= 12'h123;
      adc1_a_i <= 12'h456;
      adc1_b_i <= 12'hFED;
      read_word(4'd6, v);
      check_word("rb_data_o word 6", v, 32'hABC0_1230);
      read_word(4'd7, v);
      check_word("rb_data_o word 7", v, 32'h4560_FED0);
      for (int w = 0; w < 10; w++) begin
         if (w != 6 && w != 7) begin
            read_word(4'(w), v);
            check_word("rb_data_o unused word", v, 32'd0);
         end
      end
      report_test("adc readback", e0);

      $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// File: rtl/radio_ctrl_core.sv
// Radio control core, single dsp_clk domain
// Settings bus and run levels come straight from the ports
// ADC to rx outputs is two cycles, readback is one
`timescale 1ns/100ps

module radio_ctrl_core
   import radio_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       pps_i,
   input  adc_t       adc0_a_i,
   input  adc_t       adc0_b_i,
   input  adc_t       adc1_a_i,
   input  adc_t       adc1_b_i,
   input  logic       run_rx0_i,
   input  logic       run_rx1_i,
   input  logic [3:0] rb_addr_i,
   output sample_t    rx0_i_o,
   output sample_t    rx0_q_o,
   output sample_t    rx1_i_o,
   output sample_t    rx1_q_o,
   output logic [7:0] leds_o,
   output logic [1:0] div_sw_o,
   output logic       phy_reset_n_o,
   output logic       pps_int_o,
   output rb_word_t   rb_data_o
);

`include "radio_defs_defs.svh"

   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   rx_chan_if raw0 ();   // Front end outputs
   rx_chan_if raw1 ();
   rx_chan_if mux0 ();   // After the swap
   rx_chan_if mux1 ();

   ////////////////////////////////////////////////////////////////////////////
   // Receive path

   rx_frontend #(.BASE(`RADIO_SR_RX_FRONT0)) rx_frontend0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .adc_a_i(adc0_a_i), .adc_b_i(adc0_b_i), .run_i(run_rx0_i),
      .chan_o(raw0)
   );

   rx_frontend #(.BASE(`RADIO_SR_RX_FRONT1)) rx_frontend1 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .adc_a_i(adc1_a_i), .adc_b_i(adc1_b_i), .run_i(run_rx1_i),
      .chan_o(raw1)
   );

   frontend_swap frontend_swap0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .chan0_i(raw0), .chan1_i(raw1),
      .mux0_o(mux0), .mux1_o(mux1)
   );

   assign rx0_i_o = mux0.i;
   assign rx0_q_o = mux0.q;
   assign rx1_i_o = mux1.i;
   assign rx1_q_o = mux1.q;

   ////////////////////////////////////////////////////////////////////////////
   // Timing, control registers, readback

   vita_timer vita_timer0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .pps_i(pps_i), .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps),
      .pps_int_o(pps_int_o)
   );

   misc_ctrl_regs misc_ctrl_regs0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .run_rx0_i(mux0.run), .run_rx1_i(mux1.run),   // LEDs follow the muxed channels
      .leds_o(leds_o), .div_sw_o(div_sw_o), .phy_reset_n_o(phy_reset_n_o)
   );

   status_readback status_readback0 (
      .dsp_clk(dsp_clk), .por_rst(por_rst), .rb_addr_i(rb_addr_i),
      .adc0_a_i(adc0_a_i), .adc0_b_i(adc0_b_i),
      .adc1_a_i(adc1_a_i), .adc1_b_i(adc1_b_i),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .ovf_flags_i({mux1.ovf_q, mux1.ovf_i, mux0.ovf_q, mux0.ovf_i}),
      .rb_data_o(rb_data_o)
   );

endmodule

// File: rtl/status_readback.sv
// 16-word status readback, one cycle from address to data
// Unmapped words read as zero
`timescale 1ns/100ps

module status_readback
   import radio_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  logic [3:0] rb_addr_i,
   input  adc_t       adc0_a_i,
   input  adc_t       adc0_b_i,
   input  adc_t       adc1_a_i,
   input  adc_t       adc1_b_i,
   input  vita_time_t vita_time_i,
   input  vita_time_t vita_time_pps_i,
   input  logic [3:0] ovf_flags_i,   // ch1 q, ch1 i, ch0 q, ch0 i
   output rb_word_t   rb_data_o
);

`include "radio_defs_defs.svh"

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rb_data_o <= '0;
      end else begin
         case (rb_addr_i)
            4'd6:    rb_data_o <= {adc0_a_i, 4'b0000, adc0_b_i, 4'b0000};
            4'd7:    rb_data_o <= {adc1_a_i, 4'b0000, adc1_b_i, 4'b0000};
            4'd10:   rb_data_o <= vita_time_i[63:32];
            4'd11:   rb_data_o <= vita_time_i[31:0];
            4'd12:   rb_data_o <= `RADIO_COMPAT_NUM;
            4'd13:   rb_data_o <= {28'd0, ovf_flags_i};
            4'd14:   rb_data_o <= vita_time_pps_i[63:32];   // Time at last PPS
            4'd15:   rb_data_o <= vita_time_pps_i[31:0];
            default: rb_data_o <= '0;
         endcase
      end
   end

endmodule

// File: rtl/misc_ctrl_regs.sv
// LED, diversity switch and PHY reset settings
// LEDs are combinational from the registers and the run levels
`timescale 1ns/100ps

module misc_ctrl_regs
   import radio_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       run_rx0_i,
   input  logic       run_rx1_i,
   output logic [7:0] leds_o,
   output logic [1:0] div_sw_o,
   output logic       phy_reset_n_o
);

`include "radio_defs_defs.svh"

   localparam set_addr_t ADDR_LED_SW  = set_addr_t'(`RADIO_SR_MISC + `RADIO_MISC_LED_SW_OFS);
   localparam set_addr_t ADDR_PHY     = set_addr_t'(`RADIO_SR_MISC + `RADIO_MISC_PHY_OFS);
   localparam set_addr_t ADDR_LED_SRC = set_addr_t'(`RADIO_SR_MISC + `RADIO_MISC_LED_SRC_OFS);
   localparam set_addr_t ADDR_DIVSW1  = set_addr_t'(`RADIO_SR_DIVSW + 0);
   localparam set_addr_t ADDR_DIVSW2  = set_addr_t'(`RADIO_SR_DIVSW + 1);

   logic [7:0] led_sw;
   logic [7:0] led_src;   // 1 selects hardware
   logic [7:0] led_hw;
   logic       phy_rst;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         led_sw   <= 8'h00;
         led_src  <= `RADIO_LED_SRC_RESET;
         phy_rst  <= 1'b0;
         div_sw_o <= 2'b11;   // Both switches on
      end else if (set_stb_i) begin
         case (set_addr_i)
            ADDR_LED_SW:  led_sw <= set_data_i[7:0];
            ADDR_LED_SRC: led_src <= set_data_i[7:0];
            ADDR_PHY:     phy_rst <= set_data_i[0];
            ADDR_DIVSW1:  div_sw_o[0] <= set_data_i[0];
            ADDR_DIVSW2:  div_sw_o[1] <= set_data_i[0];
            default: ;
         endcase
      end
   end

   // Hardware pattern, rx0 on bit 3 and rx1 on bit 1
   assign led_hw = {4'b0000, run_rx0_i, 1'b0, run_rx1_i, 1'b0};

   assign leds_o        = (led_src & led_hw) | (~led_src & led_sw);
   assign phy_reset_n_o = ~phy_rst;

endmodule

// File: rtl/vita_timer.sv
// 64-bit tick counter with immediate or PPS aligned load
// pps_i is asynchronous, edge seen 3 cycles after it rises
// A PPS aligned load captures the time from before the load
`timescale 1ns/100ps

module vita_timer
   import radio_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o,
   output logic       pps_int_o
);

`include "radio_defs_defs.svh"

   localparam set_addr_t ADDR_HI   = set_addr_t'(`RADIO_SR_TIME64 + `RADIO_TIME_HI_OFS);
   localparam set_addr_t ADDR_LO   = set_addr_t'(`RADIO_SR_TIME64 + `RADIO_TIME_LO_OFS);
   localparam set_addr_t ADDR_CTRL = set_addr_t'(`RADIO_SR_TIME64 + `RADIO_TIME_CTRL_OFS);

   logic [31:0] time_hi;
   logic [31:0] time_lo;
   logic        ctrl_wr;
   logic        load_imm;   // Load cycle after an immediate request
   logic        armed;      // Load pending on next PPS
   logic        pps_s1;
   logic        pps_s2;
   logic        pps_d;
   logic        pps_edge;

   assign ctrl_wr  = set_stb_i && (set_addr_i == ADDR_CTRL);
   assign pps_edge = pps_s2 && !pps_d;

   ////////////////////////////////////////////////////////////////////////////
   // Settings

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         time_hi  <= '0;
         time_lo  <= '0;
         load_imm <= 1'b0;
         armed    <= 1'b0;
      end else begin
         if (set_stb_i && (set_addr_i == ADDR_HI))
            time_hi <= set_data_i;
         if (set_stb_i && (set_addr_i == ADDR_LO))
            time_lo <= set_data_i;
         load_imm <= ctrl_wr && !set_data_i[0];
         if (ctrl_wr)
            armed <= set_data_i[0];   // Immediate request disarms
         else if (pps_edge)
            armed <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Counter and PPS

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
         pps_s1          <= 1'b0;
         pps_s2          <= 1'b0;
         pps_d           <= 1'b0;
         pps_int_o       <= 1'b0;
      end else begin
         pps_s1    <= pps_i;   // Two flop synchronizer
         pps_s2    <= pps_s1;
         pps_d     <= pps_s2;
         pps_int_o <= pps_edge;
         if (pps_edge)
            vita_time_pps_o <= vita_time_o;
         if (load_imm || (armed && pps_edge))
            vita_time_o <= {time_hi, time_lo};
         else
            vita_time_o <= vita_time_o + 64'd1;
      end
   end

   a_pps_int_single: assert property (@(posedge dsp_clk) disable iff (por_rst)
      pps_int_o |=> !pps_int_o);

endmodule

// File: rtl/frontend_swap.sv
// Crossbar between the two receive front ends and the consumers
// Swap takes effect on the cycle after the setting is visible
`timescale 1ns/100ps

module frontend_swap
   import radio_pkg::*;
(
   input  logic      dsp_clk,
   input  logic      por_rst,
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   rx_chan_if.dst    chan0_i,
   rx_chan_if.dst    chan1_i,
   rx_chan_if.src    mux0_o,
   rx_chan_if.src    mux1_o
);

`include "radio_defs_defs.svh"

   localparam set_addr_t ADDR_SWAP = set_addr_t'(`RADIO_SR_RX_FRONT_SW);

   logic swap_q;

   // Swap setting plus the control fields of both channels
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         swap_q       <= 1'b0;
         mux0_o.run   <= 1'b0;
         mux0_o.ovf_i <= 1'b0;
         mux0_o.ovf_q <= 1'b0;
         mux1_o.run   <= 1'b0;
         mux1_o.ovf_i <= 1'b0;
         mux1_o.ovf_q <= 1'b0;
      end else begin
         if (set_stb_i && (set_addr_i == ADDR_SWAP))
            swap_q <= set_data_i[0];
         mux0_o.run   <= swap_q ? chan1_i.run   : chan0_i.run;
         mux0_o.ovf_i <= swap_q ? chan1_i.ovf_i : chan0_i.ovf_i;
         mux0_o.ovf_q <= swap_q ? chan1_i.ovf_q : chan0_i.ovf_q;
         mux1_o.run   <= swap_q ? chan0_i.run   : chan1_i.run;
         mux1_o.ovf_i <= swap_q ? chan0_i.ovf_i : chan1_i.ovf_i;
         mux1_o.ovf_q <= swap_q ? chan0_i.ovf_q : chan1_i.ovf_q;
      end
   end

   // Sample payload
   always_ff @(posedge dsp_clk) begin
      mux0_o.i <= swap_q ? chan1_i.i : chan0_i.i;
      mux0_o.q <= swap_q ? chan1_i.q : chan0_i.q;
      mux1_o.i <= swap_q ? chan0_i.i : chan1_i.i;
      mux1_o.q <= swap_q ? chan0_i.q : chan1_i.q;
   end

   a_straight_path: assert property (@(posedge dsp_clk) disable iff (por_rst)
      !swap_q |=> (mux0_o.i === $past(chan0_i.i)) && (mux0_o.q === $past(chan0_i.q))
                  && (mux0_o.run === $past(chan0_i.run)));

endmodule

// File: rtl/rx_frontend.sv
// DC offset removal for one receive channel, one cycle of latency
// Offsets are signed 16-bit, taken from the low half of the settings word
// Result is saturated to 16 bits, low byte of the sample is always zero
`timescale 1ns/100ps
`include "radio_defs_defs.svh"

module rx_frontend
   import radio_pkg::*;
#(
   parameter int BASE = `RADIO_SR_RX_FRONT0
) (
   input  logic      dsp_clk,
   input  logic      por_rst,
   input  logic      set_stb_i,
   input  set_addr_t set_addr_i,
   input  set_data_t set_data_i,
   input  adc_t      adc_a_i,
   input  adc_t      adc_b_i,
   input  logic      run_i,
   rx_chan_if.src    chan_o
);

   localparam set_addr_t ADDR_OFS_I = set_addr_t'(BASE + 0);
   localparam set_addr_t ADDR_OFS_Q = set_addr_t'(BASE + 1);

   logic signed [15:0] ofs_i;
   logic signed [15:0] ofs_q;
   logic [16:0]        cor_i;   // {ovf, value}
   logic [16:0]        cor_q;

   // Left justify, subtract, clamp to the 16-bit range
   function automatic logic [16:0] corr_sat(input adc_t smp, input logic [15:0] ofs);
      logic [16:0] diff;
      logic        ovf;
      logic [15:0] res;
      diff = {smp[`RADIO_ADC_W-1], smp, 4'b0000} - {ofs[15], ofs};
      ovf  = diff[16] ^ diff[15];   // Sign lost in 16 bits
      if (!ovf)
         res = diff[15:0];
      else if (diff[16])
         res = 16'h8000;   // Negative full scale
      else
         res = 16'h7FFF;
      return {ovf, res};
   endfunction

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         ofs_i <= '0;
         ofs_q <= '0;
      end else if (set_stb_i) begin
         if (set_addr_i == ADDR_OFS_I)
            ofs_i <= set_data_i[15:0];
         if (set_addr_i == ADDR_OFS_Q)
            ofs_q <= set_data_i[15:0];
      end
   end

   always_comb begin
      cor_i = corr_sat(adc_a_i, ofs_i);
      cor_q = corr_sat(adc_b_i, ofs_q);
   end

   // Flags and run
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         chan_o.ovf_i <= 1'b0;
         chan_o.ovf_q <= 1'b0;
         chan_o.run   <= 1'b0;
      end else begin
         chan_o.ovf_i <= cor_i[16];
         chan_o.ovf_q <= cor_q[16];
         chan_o.run   <= run_i;
      end
   end

   always_ff @(posedge dsp_clk) begin
      chan_o.i <= {cor_i[15:0], 8'h00};
      chan_o.q <= {cor_q[15:0], 8'h00};
   end

   a_ovf_i_at_limit: assert property (@(posedge dsp_clk) disable iff (por_rst)
      $rose(chan_o.ovf_i) |-> chan_o.i[23:8] inside {16'h7FFF, 16'h8000});
   a_ovf_q_at_limit: assert property (@(posedge dsp_clk) disable iff (por_rst)
      $rose(chan_o.ovf_q) |-> chan_o.q[23:8] inside {16'h7FFF, 16'h8000});

endmodule

// File: rtl/rx_chan_if.sv
// One receive channel as it leaves a front end stage
// No valid strobe since samples move every dsp_clk cycle
`timescale 1ns/100ps

interface rx_chan_if;

   radio_pkg::sample_t i;   // In-phase sample
   radio_pkg::sample_t q;   // Quadrature sample
   logic ovf_i;             // I saturated this sample
   logic ovf_q;             // Q saturated this sample
   logic run;               // Channel run level, aligned with the samples

   // Producer side
   modport src (
      output i, q, ovf_i, ovf_q, run
   );

   // Consumer side
   modport dst (
      input i, q, ovf_i, ovf_q, run
   );

endinterface

// File: rtl/radio_pkg.sv
// Shared types of the radio control core
// Widths follow the defs header

package radio_pkg;

`include "radio_defs_defs.svh"

   // One raw converter sample, two's complement
   typedef logic [`RADIO_ADC_W-1:0] adc_t;

   // Front end output sample
   // Upper 16 bits carry the corrected value
   typedef logic [`RADIO_SAMPLE_W-1:0] sample_t;

   // Settings bus
   typedef logic [`RADIO_SET_ADDR_W-1:0] set_addr_t;
   typedef logic [`RADIO_SET_DATA_W-1:0] set_data_t;

   // Free running tick count
   typedef logic [63:0] vita_time_t;

   // Status readback word
   typedef logic [31:0] rb_word_t;

endpackage

// File: include/radio_defs_defs.svh
// Register map and widths of the radio control core
// Addresses are settings bus word addresses, 8 bits wide

`ifndef RADIO_DEFS_DEFS_SVH
`define RADIO_DEFS_DEFS_SVH

// Datapath and bus widths
`define RADIO_ADC_W       12
`define RADIO_SAMPLE_W    24
`define RADIO_SET_ADDR_W  8
`define RADIO_SET_DATA_W  32

// Settings register bases
`define RADIO_SR_MISC        0    // One word per misc register
`define RADIO_SR_TIME64      10   // High, low, control
`define RADIO_SR_RX_FRONT0   20   // I offset, Q offset
`define RADIO_SR_RX_FRONT1   25
`define RADIO_SR_RX_FRONT_SW 176  // Swap bit in bit0
`define RADIO_SR_DIVSW       180  // Switch 1 and switch 2

// Offsets inside the misc block
`define RADIO_MISC_LED_SW_OFS  3
`define RADIO_MISC_PHY_OFS     4
`define RADIO_MISC_LED_SRC_OFS 6

// Offsets inside the timer block
`define RADIO_TIME_HI_OFS   0
`define RADIO_TIME_LO_OFS   1
`define RADIO_TIME_CTRL_OFS 2

// Reset values
`define RADIO_LED_SRC_RESET 8'h1E

// Bumped whenever the register map changes, major in the upper half
`define RADIO_COMPAT_NUM {16'd8, 16'd2}

`endif
